// File: tone_audio.f
+incdir+test
design/tone_audio_pkg.sv
design/audio_regs.sv
design/tone_gen.sv
design/sample_fifo.sv
design/speaker_serializer.sv
design/tone_audio_top.sv
test/tone_audio_tb.sv

// File: Bender.yml
package:
  name: tone_audio

sources:
  - files:
      - design/tone_audio_pkg.sv
      - design/audio_regs.sv
      - design/tone_gen.sv
      - design/sample_fifo.sv
      - design/speaker_serializer.sv
      - design/tone_audio_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tone_audio_tb.sv

// File: test/tone_audio_ref.svh
`ifndef TONE_AUDIO_REF_SVH
`define TONE_AUDIO_REF_SVH

// expected sound path behavior, taken from the register and tone rules

// out of range volumes snap to the nearest legal bound
function automatic int clamped_volume(input int raw);
    if (raw < int'(VOL_MIN))
        return int'(VOL_MIN);
    if (raw > int'(VOL_MAX))
        return int'(VOL_MAX);
    return raw;
endfunction

function automatic int amplitude(input int vol);
    return vol * int'(AMP_STEP);
endfunction

function automatic bit channel_silent(input int div, input bit mute);
    return mute || (div == 0);
endfunction

// one of the two allowed values for a channel, picked by sign
function automatic logic [SAMPLE_W-1:0] expected_sample(input int div, input int vol,
                                                        input bit mute, input bit neg);
    int amp;
    if (channel_silent(div, mute))
        return '0;
    amp = amplitude(vol);
    return neg ? SAMPLE_W'(-amp) : SAMPLE_W'(amp);
endfunction

// control word, volume in 2..0 and mute in bit 4
function automatic logic [31:0] ctrl_word(input int vol, input bit mute);
    return {27'b0, mute, 1'b0, 3'(vol)};
endfunction

function automatic logic [31:0] divider_readback(input logic [31:0] written);
    return written & ((32'd1 << DIV_W) - 1);  // upper bits are not stored
endfunction

`endif

// File: test/tone_audio_tb.sv
`default_nettype none

module tone_audio_tb;
    import tone_audio_pkg::*;

    localparam int    CLK_PERIOD    = 40;
    localparam int    RESET_CYCLES  = 16;
    localparam int    MAX_FRAMES    = 2000;
    localparam int    SETTLE_FRAMES = 4;           // covers fifo latency after a write
    localparam longint WATCHDOG_TIME =
        longint'(MAX_FRAMES + 100) * SAMPLE_DIV * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        mclk;
    logic        lrck;
    logic        sck;
    logic        sdin;

    // last values written, as the model sees them
    int          model_div [2];
    int          model_vol;
    bit          model_mute;

    bit          chk_on;
    int          frame_cnt;
    int          checked_cnt;
    int          runs_checked;
    int          mclk_edges;                       // active clk edges since reset
    logic [31:0] rx_q [$];

    // per channel sign run tracking
    bit          have_prev [2];
    bit          prev_neg  [2];
    bit          run_open  [2];
    int          run_len   [2];

    logic [SAMPLE_W-1:0] rx_left;
    logic [SAMPLE_W-1:0] rx_right;
    int                  left_bits;
    int                  right_bits;

    `include "tone_audio_ref.svh"

    tone_audio_top UUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mclk    (mclk),
        .lrck    (lrck),
        .sck     (sck),
        .sdin    (sdin)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);                             // middle of the access phase
        assert (pready === 1'b1) else fail_run("pready was low during a write");
        assert (pslverr === 1'b0)
            else fail_run($sformatf("pslverr raised on a write to 0x%h", addr));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        assert (pready === 1'b1) else fail_run("pready was low during a read");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        read_reg(addr, data, err);
        assert (err === 1'b0)
            else fail_run($sformatf("pslverr raised on a read of 0x%h", addr));
        assert (data === exp)
            else fail_run($sformatf("MISMATCH prdata at 0x%h: expected 0x%h, got 0x%h",
                                    addr, exp, data));
    endtask

    task automatic set_tone(input int div_l, input int div_r, input int vol_raw,
                            input bit mute);
        write_reg(ADDR_DIV_L, 32'(div_l));
        write_reg(ADDR_DIV_R, 32'(div_r));
        write_reg(ADDR_CTRL, ctrl_word(vol_raw, mute));
        model_div[0] = div_l;
        model_div[1] = div_r;
        model_vol    = clamped_volume(vol_raw);
        model_mute   = mute;
    endtask

    // one frame_cnt step per received frame
    task automatic wait_frames(input int n);
        repeat (n) @(frame_cnt);
    endtask

    // skip frames still in flight, then check a run of frames
    task automatic check_window(input int n);
        chk_on = 1'b0;
        wait_frames(SETTLE_FRAMES);
        chk_on = 1'b1;
        wait_frames(n);
        chk_on = 1'b0;
    endtask

    task automatic check_channel(input int ch, input logic [SAMPLE_W-1:0] s);
        logic [SAMPLE_W-1:0] pos;
        logic [SAMPLE_W-1:0] neg;
        int                  lo;
        string               name;
        name = (ch == 0) ? "left" : "right";
        pos  = expected_sample(model_div[ch], model_vol, model_mute, 1'b0);
        neg  = expected_sample(model_div[ch], model_vol, model_mute, 1'b1);
        assert (s === pos || s === neg)
            else fail_run($sformatf("MISMATCH %s sample: expected 0x%h or 0x%h, got 0x%h",
                                    name, pos, neg, s));
        if (channel_silent(model_div[ch], model_mute)) begin
            have_prev[ch] = 1'b0;
            run_open[ch]  = 1'b0;
        end else if (!have_prev[ch]) begin
            have_prev[ch] = 1'b1;
            prev_neg[ch]  = s[SAMPLE_W-1];
            run_len[ch]   = 1;
        end else if (s[SAMPLE_W-1] == prev_neg[ch]) begin
            run_len[ch]++;
        end else begin
            if (run_open[ch]) begin                 // only runs seen from start to end
                lo = model_div[ch] / SAMPLE_DIV - 1;
                assert (run_len[ch] >= lo && run_len[ch] <= lo + 2)
                    else fail_run($sformatf("%s run of %0d samples for divider %0d",
                                            name, run_len[ch], model_div[ch]));
                runs_checked++;
            end
            run_open[ch] = 1'b1;
            prev_neg[ch] = s[SAMPLE_W-1];
            run_len[ch]  = 1;
        end
    endtask

    // master clock is low after reset and flips every MCLK_HALF clk cycles
    always @(negedge clk) begin : mclk_check
        logic exp_mclk;
        if (rst) begin
            mclk_edges = 0;
        end else begin
            exp_mclk = 1'((mclk_edges / MCLK_HALF) % 2);
            assert (mclk === exp_mclk)
                else fail_run($sformatf("MISMATCH mclk: expected 0x%h, got 0x%h",
                                        exp_mclk, mclk));
            mclk_edges++;
        end
    end

    // serial link receiver, bits taken on rising sck
    always @(posedge sck) begin
        if (!lrck) begin
            rx_left = {rx_left[SAMPLE_W-2:0], sdin};
            left_bits++;
        end else begin
            rx_right = {rx_right[SAMPLE_W-2:0], sdin};
            right_bits++;
            if (right_bits == SAMPLE_W) begin
                if (left_bits >= SAMPLE_W) begin    // skips a partial first frame
                    rx_q.push_back({rx_left, rx_right});
                    frame_cnt++;
                end
                left_bits  = 0;
                right_bits = 0;
            end
        end
    end

    initial begin : compare
        logic [31:0] frame;
        forever begin
            wait (rx_q.size() > 0);
            frame = rx_q.pop_front();
            if (!chk_on) begin
                have_prev = '{default: 1'b0};
                run_open  = '{default: 1'b0};
            end else begin
                checked_cnt++;
                check_channel(0, frame[31:16]);
                check_channel(1, frame[15:0]);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("timeout, the run took longer than %0d frames", MAX_FRAMES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int          div_l;
        int          div_r;
        int          vol;
        int          raw_vols [3];
        logic [31:0] data;
        logic        err;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        chk_on     = 1'b0;
        model_div  = '{0, 0};
        model_vol  = int'(VOL_RESET);
        model_mute = 1'b0;
        raw_vols   = '{0, 6, 7};
        void'($urandom(32'h043e_a8cb));

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // reset state, silence on both channels
        @(negedge clk);
        assert (pready === 1'b1) else fail_run("pready low after reset");
        assert (pslverr === 1'b0) else fail_run("pslverr high after reset");
        expect_reg(ADDR_CTRL, ctrl_word(int'(VOL_RESET), 1'b0));
        check_window(20);

        // random tones
        repeat (6) begin
            div_l = $urandom_range(3071, 512);
            div_r = $urandom_range(3071, 512);
            vol   = $urandom_range(5, 1);
            set_tone(div_l, div_r, vol, 1'b0);
            check_window(40);
        end
        assert (runs_checked > 0) else fail_run("no complete sign run was seen");

        // volume clamp
        foreach (raw_vols[i]) begin
            set_tone(div_l, div_r, raw_vols[i], 1'b0);
            expect_reg(ADDR_CTRL, ctrl_word(clamped_volume(raw_vols[i]), 1'b0));
            check_window(16);
        end

        // mute and unmute
        div_l = $urandom_range(3071, 512);
        div_r = $urandom_range(3071, 512);
        set_tone(div_l, div_r, 4, 1'b1);
        check_window(16);
        set_tone(div_l, div_r, 4, 1'b0);
        check_window(16);

        // unmapped addresses and readback
        foreach (raw_vols[i]) begin
            read_reg(4'(2 * i + 1), data, err);
            assert (err === 1'b1)
                else fail_run($sformatf("no pslverr on unmapped address 0x%h", 2 * i + 1));
        end
        data = $urandom;
        write_reg(ADDR_DIV_L, data);
        expect_reg(ADDR_DIV_L, divider_readback(data));
        data = $urandom;
        write_reg(ADDR_DIV_R, data);
        expect_reg(ADDR_DIV_R, divider_readback(data));
        expect_reg(ADDR_CTRL, ctrl_word(4, 1'b0));

        // first frame after reset found the fifo empty
        expect_reg(ADDR_STATUS, 32'h1);
        wait_frames(20);
        expect_reg(ADDR_STATUS, 32'h0);

        assert (checked_cnt > 0) else fail_run("no frames were checked");
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/tone_audio_top.sv
`default_nettype none

module tone_audio_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [3:0]                 paddr,
    input  tone_audio_pkg::apb_wdata_u pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       mclk,
    output logic                       lrck,
    output logic                       sck,
    output logic                       sdin
);
    import tone_audio_pkg::*;

    tone_cfg_t    cfg;
    audio_frame_t push_frame;
    audio_frame_t head_frame;
    logic         push;
    logic         full;
    logic         pop;
    logic         empty;
    logic         underrun;

    audio_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .underrun (underrun),
        .cfg      (cfg)
    );

    tone_gen u_gen (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .push       (push),
        .push_frame (push_frame),
        .full       (full)
    );

    sample_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_frame (push_frame),
        .full       (full),
        .pop        (pop),
        .head_frame (head_frame),
        .empty      (empty)
    );

    speaker_serializer u_ser (
        .clk        (clk),
        .rst        (rst),
        .head_frame (head_frame),
        .empty      (empty),
        .pop        (pop),
        .underrun   (underrun),
        .mclk       (mclk),
        .lrck       (lrck),
        .sck        (sck),
        .sdin       (sdin)
    );

endmodule

`default_nettype wire

// File: design/speaker_serializer.sv
`default_nettype none

module speaker_serializer (
    input  logic                         clk,
    input  logic                         rst,
    input  tone_audio_pkg::audio_frame_t head_frame,
    input  logic                         empty,
    output logic                         pop,
    output logic                         underrun,
    output logic                         mclk,
    output logic                         lrck,
    output logic                         sck,
    output logic                         sdin
);
    import tone_audio_pkg::*;

    logic [$clog2(SCK_HALF)-1:0]    sck_cnt;
    logic [$clog2(2*SAMPLE_W)-1:0]  bit_cnt;    // bit being driven
    logic [$clog2(2*SAMPLE_W)-1:0]  next_bit;
    logic [2*SAMPLE_W-1:0]          shreg;
    logic                           sck_fall;
    logic                           frame_start;

    // mclk half period is a single clk cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            mclk <= 1'b0;
        else
            mclk <= ~mclk;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sck_cnt <= '0;
            sck     <= 1'b0;
        end else if (sck_cnt == SCK_HALF - 1) begin
            sck_cnt <= '0;
            sck     <= ~sck;
        end else begin
            sck_cnt <= sck_cnt + 1'b1;
        end
    end

    assign sck_fall    = (sck_cnt == SCK_HALF - 1) && sck;   // sck about to drop
    assign next_bit    = bit_cnt + 1'b1;
    assign frame_start = sck_fall && (bit_cnt == 2*SAMPLE_W - 1);

    assign pop      = frame_start && !empty;
    assign underrun = frame_start && empty;

    // bit_cnt starts at the last bit so the first falling edge opens a frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt <= '1;
            lrck    <= 1'b0;
            shreg   <= '0;
        end else if (sck_fall) begin
            bit_cnt <= next_bit;
            lrck    <= next_bit[$clog2(SAMPLE_W)];   // high for the right half
            if (frame_start)
                shreg <= empty ? '0 : head_frame;     // silence on underrun
            else
                shreg <= shreg << 1;
        end
    end

    assign sdin = shreg[2*SAMPLE_W-1];          // msb first

    assert property (@(posedge clk) disable iff (rst)
        $changed(lrck) |-> $fell(sck) && (bit_cnt == 0 || bit_cnt == SAMPLE_W))
        else $error("lrck moved off a channel boundary");

endmodule

`default_nettype wire

// File: design/sample_fifo.sv
`default_nettype none

module sample_fifo (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  tone_audio_pkg::audio_frame_t push_frame,
    output logic                         full,
    input  logic                         pop,
    output tone_audio_pkg::audio_frame_t head_frame,
    output logic                         empty
);
    import tone_audio_pkg::*;

    audio_frame_t                        mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]       wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]       rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0]     count;

    assign full       = (count == FIFO_DEPTH);
    assign empty      = (count == 0);
    assign head_frame = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_frame;
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // both or neither
            endcase
        end
    end

    // neighbours must respect the handshake
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into full fifo");

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop from empty fifo");

endmodule

`default_nettype wire

// File: design/tone_gen.sv
`default_nettype none

module tone_gen (
    input  logic                         clk,
    input  logic                         rst,
    input  tone_audio_pkg::tone_cfg_t    cfg,
    output logic                         push,
    output tone_audio_pkg::audio_frame_t push_frame,
    input  logic                         full
);
    import tone_audio_pkg::*;

    logic [$clog2(SAMPLE_DIV)-1:0] tick_cnt;
    logic                          tick;
    logic [1:0][DIV_W-1:0]         div;         // 0 left, 1 right
    logic [1:0][DIV_W-1:0]         ph_cnt;
    logic [1:0]                    pol;
    logic [SAMPLE_W-1:0]           amp;
    logic [1:0][SAMPLE_W-1:0]      chan_val;
    audio_frame_t                  next_frame;

    assign div[0] = cfg.div_left;
    assign div[1] = cfg.div_right;

    assign tick = (tick_cnt == SAMPLE_DIV - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    // square wave per channel, half period = divider cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ph_cnt <= '0;
            pol    <= '0;
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                if (div[ch] == '0) begin
                    ph_cnt[ch] <= '0;
                    pol[ch]    <= 1'b0;
                end else if (ph_cnt[ch] >= div[ch] - 1'b1) begin   // >= covers a shrinking divider
                    ph_cnt[ch] <= '0;
                    pol[ch]    <= ~pol[ch];
                end else begin
                    ph_cnt[ch] <= ph_cnt[ch] + 1'b1;
                end
            end
        end
    end

    assign amp = SAMPLE_W'(cfg.volume) * AMP_STEP;

    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            if (cfg.mute || div[ch] == '0)
                chan_val[ch] = '0;
            else
                chan_val[ch] = pol[ch] ? -amp : amp;
        end
        next_frame.left  = chan_val[0];
        next_frame.right = chan_val[1];
    end

    // a tick while a frame is still stuck on a full fifo is dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            if (push && !full)
                push <= 1'b0;
            if (tick && !(push && full))
                push <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tick && !(push && full))
            push_frame <= next_frame;
    end

endmodule

`default_nettype wire

// File: design/audio_regs.sv
`default_nettype none

module audio_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [3:0]               paddr,
    input  tone_audio_pkg::apb_wdata_u pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     underrun,
    output tone_audio_pkg::tone_cfg_t cfg
);
    import tone_audio_pkg::*;

    logic       access;
    logic       addr_hit;
    logic       wr_en;
    logic       status_rd;
    logic       underrun_flag;
    apb_wdata_u rd_ctrl;

    function automatic logic [VOL_W-1:0] clamp_vol(input logic [VOL_W-1:0] v);
        if (v < VOL_MIN)
            return VOL_MIN;
        if (v > VOL_MAX)
            return VOL_MAX;
        return v;
    endfunction

    assign access   = psel && penable;
    assign addr_hit = (paddr == ADDR_DIV_L) || (paddr == ADDR_DIV_R) ||
                      (paddr == ADDR_CTRL)  || (paddr == ADDR_STATUS);
    assign wr_en     = access && pwrite;
    assign status_rd = access && !pwrite && (paddr == ADDR_STATUS);

    assign pready  = 1'b1;                      // zero wait states
    assign pslverr = access && !addr_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.div_left  <= '0;                // silence
            cfg.div_right <= '0;
            cfg.volume    <= VOL_RESET;
            cfg.mute      <= 1'b0;
        end else if (wr_en) begin
            case (paddr)
                ADDR_DIV_L: cfg.div_left  <= pwdata.div_view.div;
                ADDR_DIV_R: cfg.div_right <= pwdata.div_view.div;
                ADDR_CTRL: begin
                    cfg.volume <= clamp_vol(pwdata.ctrl_view.volume);
                    cfg.mute   <= pwdata.ctrl_view.mute;
                end
                default: ;
            endcase
        end
    end

    // sticky, a new underrun beats the clearing read
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            underrun_flag <= 1'b0;
        else if (underrun)
            underrun_flag <= 1'b1;
        else if (status_rd)
            underrun_flag <= 1'b0;
    end

    always_comb begin
        rd_ctrl                  = '0;
        rd_ctrl.ctrl_view.volume = cfg.volume;
        rd_ctrl.ctrl_view.mute   = cfg.mute;
        case (paddr)
            ADDR_DIV_L:  prdata = {{(32-DIV_W){1'b0}}, cfg.div_left};
            ADDR_DIV_R:  prdata = {{(32-DIV_W){1'b0}}, cfg.div_right};
            ADDR_CTRL:   prdata = rd_ctrl;
            ADDR_STATUS: prdata = {31'b0, underrun_flag};
            default:     prdata = '0;
        endcase
    end

    // access phase must follow a setup phase
    assert property (@(posedge clk) disable iff (rst) $rose(penable) |-> psel)
        else $error("penable rose without psel");

endmodule

`default_nettype wire

// File: design/tone_audio_pkg.sv
`default_nettype none

package tone_audio_pkg;

    // data widths
    localparam int SAMPLE_W = 16;
    localparam int DIV_W    = 22;                // tone divider, clock cycles
    localparam int VOL_W    = 3;

    localparam logic [VOL_W-1:0] VOL_MIN   = 3'd1;
    localparam logic [VOL_W-1:0] VOL_MAX   = 3'd5;
    localparam logic [VOL_W-1:0] VOL_RESET = 3'd3;

    localparam logic [SAMPLE_W-1:0] AMP_STEP = 16'h1000;   // per volume step

    // timing, all in clk cycles
    localparam int SAMPLE_DIV = 256;             // one produced frame
    localparam int SCK_HALF   = 4;               // 32 bits * 2 * 4 = 256
    localparam int MCLK_HALF  = 1;

    localparam int FIFO_DEPTH = 4;

    // apb byte addresses
    localparam logic [3:0] ADDR_DIV_L  = 4'h0;
    localparam logic [3:0] ADDR_DIV_R  = 4'h4;
    localparam logic [3:0] ADDR_CTRL   = 4'h8;
    localparam logic [3:0] ADDR_STATUS = 4'hc;

    // one stereo sample, also the fifo word
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } audio_frame_t;

    typedef struct packed {
        logic [DIV_W-1:0] div_left;
        logic [DIV_W-1:0] div_right;
        logic [VOL_W-1:0] volume;
        logic             mute;
    } tone_cfg_t;

    typedef struct packed {
        logic [31-DIV_W:0] unused;
        logic [DIV_W-1:0]  div;
    } apb_div_view_t;

    typedef struct packed {
        logic [26:0]      unused;
        logic             mute;                  // bit 4
        logic             rsvd;                  // bit 3
        logic [VOL_W-1:0] volume;                // bits 2..0
    } apb_ctrl_view_t;

    // write word, meaning picked by address
    typedef union packed {
        apb_div_view_t  div_view;
        apb_ctrl_view_t ctrl_view;
    } apb_wdata_u;

endpackage

`default_nettype wire
